// File: design/mandel_pkg.sv
`default_nettype none

package mandel_pkg;

    // escape count, also the width of one framebuffer nibble.
    typedef logic [3:0] count_t;

    // signed coordinate with 7 fraction bits.
    typedef logic signed [9:0] coord_t;

    // unsigned pixel step with 7 fraction bits.
    typedef logic [8:0] step_t;

    // signed working value with 12 fraction bits.
    typedef logic signed [17:0] fix_t;

    // one colour channel of the VGA output.
    typedef logic [3:0] color_t;

    // the configuration word is sent least significant bit first.
    localparam int CFG_BITS = 33;
    typedef logic [CFG_BITS-1:0] cfg_word_t;

    // field positions inside the configuration word.
    localparam int CFG_MAX_ITER_LSB = 0;
    localparam int CFG_X0_LSB       = 4;
    localparam int CFG_Y0_LSB       = 14;
    localparam int CFG_STEP_LSB     = 24;

    // vertical phase of the scan generator.
    typedef enum logic [1:0] {
        SCAN_ACTIVE,
        SCAN_FRONT_PORCH,
        SCAN_SYNC,
        SCAN_BACK_PORCH
    } scan_state_t;

endpackage

`default_nettype wire

// File: design/fb_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fb_if
    import mandel_pkg::*;
();

    count_t wdata;
    logic   write;
    logic   reset_write_ptr;
    logic   read;
    logic   reset_read_ptr;
    count_t rdata;

    // the renderer owns the write side.
    modport writer (output wdata, output write, output reset_write_ptr);

    // the scan generator owns the read side.
    modport reader (output read, output reset_read_ptr, input rdata);

    modport memory (
        input  wdata,
        input  write,
        input  reset_write_ptr,
        input  read,
        input  reset_read_ptr,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/debounce.sv
`timescale 1ns/10ps
`default_nettype none

module debounce #(
    parameter int DELAY = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic in,
    output logic out
);

    localparam int CNT_W = (DELAY > 1) ? $clog2(DELAY + 1) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DELAY - 1);

    logic [CNT_W-1:0] stable_cnt;

    // the counter runs only while the input differs from the output.
    // any return to the old level restarts it, so short glitches vanish.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stable_cnt <= '0;
            out        <= 1'b0;
        end
        else if (in == out)
        begin
            stable_cnt <= '0;
        end
        else if (stable_cnt == LAST)
        begin
            stable_cnt <= '0;
            out        <= in;
        end
        else
        begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/config_loader.sv
`timescale 1ns/10ps
`default_nettype none

module config_loader
    import mandel_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      trigger,
    input  cfg_word_t cfg_word,
    output logic      cfg_en,
    output logic      cfg_sclk,
    output logic      cfg_sdata,
    output logic      cfg_loaded
);

    localparam int CNT_W = $clog2(CFG_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(CFG_BITS - 1);

    typedef enum logic [2:0] {
        L_IDLE,
        L_ENABLE,
        L_HIGH,
        L_LOW,
        L_FINISH
    } load_state_t;

    load_state_t      state;
    logic             boot;
    logic             trigger_d;
    logic             start;
    logic [CNT_W-1:0] bit_cnt;
    cfg_word_t        shift_reg;

    // one load runs right after reset, later loads follow button presses.
    // presses that arrive while a word is being shifted are dropped.
    assign start = (state == L_IDLE) && (boot || (trigger && !trigger_d));

    assign cfg_sdata = shift_reg[0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= L_IDLE;
            boot       <= 1'b1;
            trigger_d  <= 1'b0;
            bit_cnt    <= '0;
            cfg_en     <= 1'b0;
            cfg_sclk   <= 1'b0;
            cfg_loaded <= 1'b0;
        end
        else
        begin
            trigger_d <= trigger;
            case (state)
                L_IDLE:
                begin
                    if (start)
                    begin
                        boot       <= 1'b0;
                        cfg_loaded <= 1'b0;
                        state      <= L_ENABLE;
                    end
                end
                L_ENABLE:
                begin
                    cfg_en  <= 1'b1;
                    bit_cnt <= '0;
                    state   <= L_HIGH;
                end
                L_HIGH:
                begin
                    cfg_sclk <= 1'b1;
                    state    <= L_LOW;
                end
                L_LOW:
                begin
                    cfg_sclk <= 1'b0;
                    bit_cnt  <= bit_cnt + 1'b1;
                    state    <= (bit_cnt == LAST_BIT) ? L_FINISH : L_HIGH;
                end
                default:
                begin
                    cfg_en     <= 1'b0;
                    cfg_loaded <= 1'b1;
                    state      <= L_IDLE;
                end
            endcase
        end
    end

    // the word is captured at the start and moves down one bit after each low phase.
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            shift_reg <= cfg_word;
        end
        else if (state == L_LOW)
        begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

// File: design/mandel_render.sv
`timescale 1ns/10ps
`default_nettype none

module mandel_render
    import mandel_pkg::*;
#(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic cfg_en,
    input  logic cfg_sclk,
    input  logic cfg_sdata,
    fb_if.writer fb,
    output logic frame_ready
);

    localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int ROW_W = (IMG_H > 1) ? $clog2(IMG_H) : 1;
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(IMG_W - 1);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(IMG_H - 1);

    // 4.0 with 12 fraction bits.
    localparam logic [24:0] ESCAPE_LIMIT = 25'd16384;

    typedef enum logic [1:0] {
        R_IDLE,
        R_CLEAR,
        R_ITER
    } render_state_t;

    render_state_t      state;
    cfg_word_t          rx_shift;
    cfg_word_t          cfg;
    logic               sclk_d;
    logic               en_d;
    logic               cfg_done;
    logic [COL_W-1:0]   col;
    logic [ROW_W-1:0]   row;
    fix_t               cx;
    fix_t               cy;
    fix_t               zx;
    fix_t               zy;
    count_t             n;

    count_t             max_iter;
    coord_t             x0;
    coord_t             y0;
    step_t              step;
    fix_t               x0_f;
    fix_t               y0_f;
    fix_t               step_f;

    logic signed [35:0] pxx;
    logic signed [35:0] pyy;
    logic signed [35:0] pxy;
    logic signed [23:0] sxx;
    logic signed [23:0] syy;
    logic signed [23:0] sxy;
    logic signed [23:0] zx_wide;
    logic signed [23:0] zy_wide;
    logic        [24:0] mag;
    logic               stop;

    assign cfg_done = en_d && !cfg_en;

    assign max_iter = cfg[CFG_MAX_ITER_LSB +: $bits(count_t)];
    assign x0       = cfg[CFG_X0_LSB +: $bits(coord_t)];
    assign y0       = cfg[CFG_Y0_LSB +: $bits(coord_t)];
    assign step     = cfg[CFG_STEP_LSB +: $bits(step_t)];

    // move the 7 fraction bits of the configuration up to 12.
    assign x0_f   = {{3{x0[9]}}, x0, 5'b0};
    assign y0_f   = {{3{y0[9]}}, y0, 5'b0};
    assign step_f = {4'b0, step, 5'b0};

    assign pxx = zx * zx;
    assign pyy = zy * zy;
    assign pxy = zx * zy;
    assign sxx = 24'(pxx >>> 12);
    assign syy = 24'(pyy >>> 12);
    assign sxy = 24'(pxy >>> 12);

    // the squares are never negative, so the magnitude needs no sign bit.
    assign mag = {1'b0, sxx} + {1'b0, syy};

    assign zx_wide = sxx - syy + cx;
    assign zy_wide = (sxy <<< 1) + cy;

    // z holds the result of n iterations.
    // its escape test uses this cycle's squares, which keeps one multiply per path.
    assign stop = (n == max_iter) || (mag > ESCAPE_LIMIT);

    assign fb.wdata           = n;
    assign fb.write           = (state == R_ITER) && stop;
    assign fb.reset_write_ptr = (state == R_CLEAR);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= R_IDLE;
            frame_ready <= 1'b0;
            sclk_d      <= 1'b0;
            en_d        <= 1'b0;
        end
        else
        begin
            sclk_d <= cfg_sclk;
            en_d   <= cfg_en;
            if (cfg_done)
            begin
                state       <= R_CLEAR;
                frame_ready <= 1'b0;
            end
            else if (state == R_CLEAR)
            begin
                state <= R_ITER;
            end
            else if ((state == R_ITER) && stop && (col == LAST_COL) && (row == LAST_ROW))
            begin
                state       <= R_IDLE;
                frame_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cfg_en && cfg_sclk && !sclk_d)
        begin
            rx_shift <= {cfg_sdata, rx_shift[CFG_BITS-1:1]};
        end
        if (cfg_done)
        begin
            cfg <= rx_shift;
        end

        if (state == R_CLEAR)
        begin
            col <= '0;
            row <= '0;
            cx  <= x0_f;
            cy  <= y0_f;
            zx  <= '0;
            zy  <= '0;
            n   <= '0;
        end
        else if (state == R_ITER)
        begin
            if (stop)
            begin
                zx <= '0;
                zy <= '0;
                n  <= '0;
                if (col == LAST_COL)
                begin
                    col <= '0;
                    row <= row + 1'b1;
                    cx  <= x0_f;
                    cy  <= cy + step_f;
                end
                else
                begin
                    col <= col + 1'b1;
                    cx  <= cx + step_f;
                end
            end
            else
            begin
                zx <= zx_wide[17:0];
                zy <= zy_wide[17:0];
                n  <= n + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/framebuffer.sv
`timescale 1ns/10ps
`default_nettype none

module framebuffer
    import mandel_pkg::*;
#(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic  clk,
    input  logic  reset,
    fb_if.memory  fb
);

    localparam int DEPTH = IMG_W * IMG_H;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    count_t           mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;

    // a pointer reset wins over a write in the same cycle.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            if (fb.reset_write_ptr)
            begin
                wptr <= '0;
            end
            else if (fb.write)
            begin
                wptr <= (wptr == LAST) ? '0 : wptr + 1'b1;
            end

            if (fb.reset_read_ptr)
            begin
                rptr <= '0;
            end
            else if (fb.read)
            begin
                rptr <= (rptr == LAST) ? '0 : rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fb.write && !fb.reset_write_ptr)
        begin
            mem[wptr] <= fb.wdata;
        end
        fb.rdata <= mem[rptr];
    end

endmodule

`default_nettype wire

// File: design/vga_scan.sv
`timescale 1ns/10ps
`default_nettype none

module vga_scan
    import mandel_pkg::*;
#(
    parameter int IMG_W  = 8,
    parameter int IMG_H  = 6,
    parameter int H_FP   = 2,
    parameter int H_SYNC = 3,
    parameter int H_BP   = 2,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 1
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   frame_ready,
    fb_if.reader   fb,
    output color_t vga_r,
    output color_t vga_g,
    output color_t vga_b,
    output logic   hsync,
    output logic   vsync
);

    localparam int H_TOTAL = IMG_W + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = IMG_H + V_FP + V_SYNC + V_BP;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam logic [HW-1:0] H_ACT    = HW'(IMG_W);
    localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] HS_START = HW'(IMG_W + H_FP);
    localparam logic [HW-1:0] HS_END   = HW'(IMG_W + H_FP + H_SYNC);

    logic [HW-1:0] hcnt;
    logic [HW-1:0] hcnt_next;
    logic [VW-1:0] line;
    logic [VW-1:0] line_next;
    logic [VW-1:0] phase_last;
    scan_state_t   vstate;
    scan_state_t   vstate_next;
    logic          active;

    // the position of the next cycle decides the read, which keeps it one pixel ahead.
    always_comb
    begin
        case (vstate)
            SCAN_ACTIVE:      phase_last = VW'(IMG_H - 1);
            SCAN_FRONT_PORCH: phase_last = VW'(V_FP - 1);
            SCAN_SYNC:        phase_last = VW'(V_SYNC - 1);
            default:          phase_last = VW'(V_BP - 1);
        endcase

        hcnt_next   = hcnt + 1'b1;
        line_next   = line;
        vstate_next = vstate;
        if (hcnt == H_LAST)
        begin
            hcnt_next = '0;
            if (line == phase_last)
            begin
                line_next = '0;
                case (vstate)
                    SCAN_ACTIVE:      vstate_next = SCAN_FRONT_PORCH;
                    SCAN_FRONT_PORCH: vstate_next = SCAN_SYNC;
                    SCAN_SYNC:        vstate_next = SCAN_BACK_PORCH;
                    default:          vstate_next = SCAN_ACTIVE;
                endcase
            end
            else
            begin
                line_next = line + 1'b1;
            end
        end
    end

    assign active = (vstate == SCAN_ACTIVE) && (hcnt < H_ACT);

    assign fb.read           = (vstate_next == SCAN_ACTIVE) && (hcnt_next < H_ACT);
    assign fb.reset_read_ptr = (vstate == SCAN_SYNC);

    // syncs and colour share one register stage so they stay aligned.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hcnt   <= '0;
            line   <= '0;
            vstate <= SCAN_FRONT_PORCH;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            vga_r  <= '0;
            vga_g  <= '0;
            vga_b  <= '0;
        end
        else
        begin
            hcnt   <= hcnt_next;
            line   <= line_next;
            vstate <= vstate_next;
            hsync  <= !((hcnt >= HS_START) && (hcnt < HS_END));
            vsync  <= (vstate != SCAN_SYNC);
            if (active && frame_ready)
            begin
                vga_r <= fb.rdata;
                vga_g <= ~fb.rdata;
                vga_b <= (fb.rdata == '0) ? 4'hF : 4'h0;
            end
            else
            begin
                vga_r <= '0;
                vga_g <= '0;
                vga_b <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mandel_fpga_top.sv
`timescale 1ns/10ps
`default_nettype none

module mandel_fpga_top
    import mandel_pkg::*;
#(
    parameter int IMG_W    = 32,
    parameter int IMG_H    = 24,
    parameter int H_FP     = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BP     = 4,
    parameter int V_FP     = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 2,
    parameter int DEBOUNCE = 125000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      btn_load,
    input  cfg_word_t cfg_word,
    output color_t    vga_r,
    output color_t    vga_g,
    output color_t    vga_b,
    output logic      hsync,
    output logic      vsync,
    output logic      cfg_loaded,
    output logic      frame_ready
);

    logic btn_clean;
    logic cfg_en;
    logic cfg_sclk;
    logic cfg_sdata;

    fb_if fb ();

    debounce #(
        .DELAY (DEBOUNCE)
    ) u_debounce (
        .clk   (clk),
        .reset (reset),
        .in    (btn_load),
        .out   (btn_clean)
    );

    config_loader u_config_loader (
        .clk        (clk),
        .reset      (reset),
        .trigger    (btn_clean),
        .cfg_word   (cfg_word),
        .cfg_en     (cfg_en),
        .cfg_sclk   (cfg_sclk),
        .cfg_sdata  (cfg_sdata),
        .cfg_loaded (cfg_loaded)
    );

    mandel_render #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_render (
        .clk         (clk),
        .reset       (reset),
        .cfg_en      (cfg_en),
        .cfg_sclk    (cfg_sclk),
        .cfg_sdata   (cfg_sdata),
        .fb          (fb.writer),
        .frame_ready (frame_ready)
    );

    framebuffer #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_framebuffer (
        .clk   (clk),
        .reset (reset),
        .fb    (fb.memory)
    );

    vga_scan #(
        .IMG_W  (IMG_W),
        .IMG_H  (IMG_H),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) u_vga_scan (
        .clk         (clk),
        .reset       (reset),
        .frame_ready (frame_ready),
        .fb          (fb.reader),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .hsync       (hsync),
        .vsync       (vsync)
    );

endmodule

`default_nettype wire

// File: dv/mandel_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mandel_asserts
    import mandel_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   cfg_en,
    input logic   cfg_sclk,
    input logic   fb_write,
    input logic   frame_ready,
    input color_t vga_r,
    input color_t vga_g,
    input color_t vga_b,
    input logic   hsync,
    input logic   vsync
);

    // the serial clock may only pulse inside an enable window.
    sclk_in_window: assert property (
        @(posedge clk) disable iff (reset) cfg_sclk |-> cfg_en
    )
    else $error("cfg_sclk is high while cfg_en is low");

    // a finished frame stays untouched until the next load clears frame_ready.
    no_write_when_ready: assert property (
        @(posedge clk) disable iff (reset) fb_write |-> !frame_ready
    )
    else $error("framebuffer written while frame_ready is high");

    // sync intervals lie outside the active area, so the picture is dark there.
    dark_during_sync: assert property (
        @(posedge clk) disable iff (reset) (!hsync || !vsync) |-> ({vga_r, vga_g, vga_b} == '0)
    )
    else $error("colour is not zero during a sync pulse");

endmodule

`default_nettype wire

// File: dv/tb_mandel.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mandel
    import mandel_pkg::*;
();

    localparam int IMG_W        = 8;
    localparam int IMG_H        = 6;
    localparam int H_FP         = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BP         = 2;
    localparam int V_FP         = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BP         = 1;
    localparam int DEBOUNCE     = 4;
    localparam int H_TOTAL      = IMG_W + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = IMG_H + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int LOAD_LIMIT   = 100;
    localparam int RENDER_LIMIT = IMG_W * IMG_H * 16 + 20;
    localparam int SEL_LOADED   = 0;
    localparam int SEL_READY    = 1;
    localparam int SEL_VSYNC    = 2;

    // each row is one step. The boot load and a short glitch come before the held presses.
    localparam int ROWS = 5;
    string row_name   [ROWS] = '{"boot", "glitch", "zoom", "zero_iter", "wide"};
    int    row_iter   [ROWS] = '{8, 15, 15, 0, 12};
    int    row_x0     [ROWS] = '{-256, -64, -128, 100, -320};
    int    row_y0     [ROWS] = '{-128, -64, -64, -50, -192};
    int    row_step   [ROWS] = '{48, 8, 16, 30, 64};
    int    row_press  [ROWS] = '{0, 2, 6, 5, 8};
    bit    row_reload [ROWS] = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1};

    logic        clk = 1'b0;
    logic        reset;
    logic        btn_load;
    cfg_word_t   cfg_word;
    color_t      vga_r;
    color_t      vga_g;
    color_t      vga_b;
    logic        hsync;
    logic        vsync;
    logic        cfg_loaded;
    logic        frame_ready;
    logic [11:0] rgb;

    int errors;
    int checks;
    int cur_iter;
    int cur_x0;
    int cur_y0;
    int cur_step;

    assign rgb = {vga_r, vga_g, vga_b};

    mandel_fpga_top #(
        .IMG_W    (IMG_W),
        .IMG_H    (IMG_H),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP),
        .DEBOUNCE (DEBOUNCE)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .btn_load    (btn_load),
        .cfg_word    (cfg_word),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .hsync       (hsync),
        .vsync       (vsync),
        .cfg_loaded  (cfg_loaded),
        .frame_ready (frame_ready)
    );

    bind mandel_fpga_top mandel_asserts u_asserts (
        .clk         (clk),
        .reset       (reset),
        .cfg_en      (cfg_en),
        .cfg_sclk    (cfg_sclk),
        .fb_write    (fb.write),
        .frame_ready (frame_ready),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    initial
    begin
        forever
        begin
            #5 clk = ~clk;
        end
    end

    // the fields run up from the least significant bit as max_iter, x0, y0 and step.
    function automatic cfg_word_t make_cfg(input int max_iter, input int x0, input int y0,
                                           input int step);
        return {step[8:0], y0[9:0], x0[9:0], max_iter[3:0]};
    endfunction

    function automatic longint wrap18(input longint v);
        longint r;
        r = v & 64'h3FFFF;
        if (r >= 64'sd131072)
        begin
            r = r - 64'sd262144;
        end
        return r;
    endfunction

    // escape count with 12 fraction bits; each product is shifted before use.
    function automatic int escape_count(input int max_iter, input int x0, input int y0,
                                        input int step, input int col, input int row);
        longint cx;
        longint cy;
        longint zx;
        longint zy;
        longint next_x;
        longint mag;
        int     n;
        bit     escaped;
        cx      = wrap18(longint'(x0 + col * step) * 32);
        cy      = wrap18(longint'(y0 + row * step) * 32);
        zx      = 0;
        zy      = 0;
        n       = 0;
        escaped = 1'b0;
        while ((n != max_iter) && !escaped)
        begin
            next_x  = wrap18(((zx * zx) >>> 12) - ((zy * zy) >>> 12) + cx);
            zy      = wrap18(2 * ((zx * zy) >>> 12) + cy);
            zx      = next_x;
            n       = n + 1;
            mag     = ((zx * zx) >>> 12) + ((zy * zy) >>> 12);
            escaped = (mag > 64'sd16384);
        end
        return n;
    endfunction

    // red is the count, green its inverse, blue lights up only for count 0.
    function automatic int palette(input int n);
        int blue;
        blue = (n == 0) ? 15 : 0;
        return ((n & 15) << 8) | ((~n & 15) << 4) | blue;
    endfunction

    function automatic logic level_of(input int sel);
        case (sel)
            SEL_LOADED: return cfg_loaded;
            SEL_READY:  return frame_ready;
            default:    return vsync;
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else
        begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic wait_level(input int sel, input logic level, input int limit,
                              input string what);
        int cycles;
        cycles = 0;
        while ((level_of(sel) != level) && (cycles < limit))
        begin
            @(negedge clk);
            cycles++;
        end
        if (level_of(sel) != level)
        begin
            errors++;
            $display("timeout after %0d cycles waiting for %s", limit, what);
            $display("Done: errors found");
            $finish;
        end
    endtask

    // colour lags frame_ready by one register, so checks start a cycle late.
    task automatic watch_render(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!frame_ready && (cycles < RENDER_LIMIT))
        begin
            check_value(name, "rgb while rendering", 0, int'(rgb));
            @(negedge clk);
            cycles++;
        end
        if (!frame_ready)
        begin
            errors++;
            $display("timeout after %0d cycles waiting for frame_ready", RENDER_LIMIT);
            $display("Done: errors found");
            $finish;
        end
        check_value(name, "rgb as frame_ready rises", 0, int'(rgb));
    endtask

    task automatic watch_steady(input string name, input int cycles);
        repeat (cycles)
        begin
            check_value(name, "cfg_loaded", 1, int'(cfg_loaded));
            check_value(name, "frame_ready", 1, int'(frame_ready));
            @(negedge clk);
        end
    endtask

    // cycle k after the vsync fall shows scan position k of the frame.
    task automatic capture_frame(input string name);
        int    k;
        int    line;
        int    h;
        int    act_row;
        int    want;
        bit    sync_low;
        string what;
        wait_level(SEL_VSYNC, 1'b1, FRAME_CYCLES, "vsync high before a frame");
        wait_level(SEL_VSYNC, 1'b0, FRAME_CYCLES, "vsync to fall");
        for (k = 0; k < FRAME_CYCLES; k++)
        begin
            line     = k / H_TOTAL;
            h        = k % H_TOTAL;
            act_row  = line - V_SYNC - V_BP;
            sync_low = (h >= IMG_W + H_FP) && (h < IMG_W + H_FP + H_SYNC);
            want     = 0;
            what     = "rgb in blanking";
            check_value(name, "vsync", (line < V_SYNC) ? 0 : 1, int'(vsync));
            check_value(name, "hsync", sync_low ? 0 : 1, int'(hsync));
            if ((act_row >= 0) && (act_row < IMG_H) && (h < IMG_W))
            begin
                want = palette(escape_count(cur_iter, cur_x0, cur_y0, cur_step, h, act_row));
                what = $sformatf("rgb at x %0d y %0d", h, act_row);
                if (cur_iter == 0)
                begin
                    check_value(name, "rgb with max_iter 0", 'h0FF, int'(rgb));
                end
            end
            check_value(name, what, want, int'(rgb));
            @(negedge clk);
        end
        check_value(name, "vsync after one frame", 0, int'(vsync));
    endtask

    task automatic apply_row(input int i);
        string name;
        name = row_name[i];
        if (i == 0)
        begin
            wait_level(SEL_LOADED, 1'b1, LOAD_LIMIT, "cfg_loaded after reset");
            check_value(name, "frame_ready before render", 0, int'(frame_ready));
            watch_render(name);
        end
        else if (row_reload[i])
        begin
            cfg_word = make_cfg(row_iter[i], row_x0[i], row_y0[i], row_step[i]);
            btn_load = 1'b1;
            repeat (row_press[i]) @(negedge clk);
            btn_load = 1'b0;
            wait_level(SEL_LOADED, 1'b0, LOAD_LIMIT, "cfg_loaded to drop after a press");
            wait_level(SEL_LOADED, 1'b1, LOAD_LIMIT, "cfg_loaded after a press");
            wait_level(SEL_READY, 1'b0, 4, "frame_ready to drop after a load");
            watch_render(name);
        end
        else
        begin
            // a glitch shorter than the debounce delay must not start a load.
            cfg_word = make_cfg(row_iter[i], row_x0[i], row_y0[i], row_step[i]);
            btn_load = 1'b1;
            watch_steady(name, row_press[i]);
            btn_load = 1'b0;
            watch_steady(name, DEBOUNCE + LOAD_LIMIT);
        end
        if (row_reload[i])
        begin
            cur_iter = row_iter[i];
            cur_x0   = row_x0[i];
            cur_y0   = row_y0[i];
            cur_step = row_step[i];
        end
        capture_frame(name);
    endtask

    initial
    begin
        int i;
        errors   = 0;
        checks   = 0;
        reset    = 1'b1;
        btn_load = 1'b0;
        cfg_word = make_cfg(row_iter[0], row_x0[0], row_y0[0], row_step[0]);
        repeat (2) @(negedge clk);
        reset = 1'b0;
        for (i = 0; i < ROWS; i++)
        begin
            apply_row(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/mandel_pkg.sv
design/fb_if.sv
design/debounce.sv
design/config_loader.sv
design/mandel_render.sv
design/framebuffer.sv
design/vga_scan.sv
design/mandel_fpga_top.sv
dv/mandel_asserts.sv
dv/tb_mandel.sv

// File: run.sh
#!/bin/sh
# Build and run the Mandelbrot viewer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mandel -f vlog.f -o sim_mandel

./obj_dir/sim_mandel | tee sim.log

# The run passes only if the testbench printed its pass line.
grep -q "^Done: no errors$" sim.log
